// ==== tb.f ====
rtl/soc_bus_pkg.sv
rtl/soc_periph_pkg.sv
rtl/wb_periph_decode.sv
rtl/sys_ctrl.sv
rtl/gpio_regs.sv
rtl/periph_subsys_top.sv
bench/periph_checker.sv
bench/tb_periph_subsys.sv

// ==== bench/tb_periph_subsys.sv ====
// Testbench top with clock, reset, LFSR stimulus, bus master tasks and test sequence
`default_nettype none

module tb_periph_subsys;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ACK_LIMIT = 8;
   localparam int IRQ_LIMIT = 64;

   logic                    clk;
   logic                    arst_n;
   soc_bus_pkg::wb_adr_t    wb_adr;
   soc_bus_pkg::wb_dat_t    wb_dat;
   logic                    wb_we;
   logic                    wb_cyc;
   logic                    wb_stb;
   soc_bus_pkg::wb_dat_t    wb_rdt;
   logic                    wb_ack;
   logic                    ram_init_done;
   logic                    ram_init_error;
   soc_periph_pkg::gpio_t   gpio_in;
   soc_periph_pkg::gpio_t   gpio_out;
   soc_periph_pkg::gpio_t   gpio_oe;
   logic                    gpio_irq;
   logic                    timer_irq;
   soc_periph_pkg::sw_irq_t sw_irq;
   logic                    nmi_int;
   soc_bus_pkg::wb_dat_t    nmi_vec;
   logic [31:0]             lfsr_state;
   int                      err_mark;
   int                      sel;
   int                      n;
   soc_bus_pkg::wb_adr_t    adr;
   soc_bus_pkg::wb_dat_t    rdt;
   soc_bus_pkg::wb_dat_t    t0;
   soc_bus_pkg::wb_dat_t    t1;
   soc_bus_pkg::wb_dat_t    hi;
   soc_bus_pkg::region_t    region;

   periph_subsys_top u_dut (
      .clk              (clk),
      .i_arst_n         (arst_n),
      .i_wb_adr         (wb_adr),
      .i_wb_dat         (wb_dat),
      .i_wb_we          (wb_we),
      .i_wb_cyc         (wb_cyc),
      .i_wb_stb         (wb_stb),
      .o_wb_rdt         (wb_rdt),
      .o_wb_ack         (wb_ack),
      .i_ram_init_done  (ram_init_done),
      .i_ram_init_error (ram_init_error),
      .i_gpio_in        (gpio_in),
      .o_gpio_out       (gpio_out),
      .o_gpio_oe        (gpio_oe),
      .o_gpio_irq       (gpio_irq),
      .o_timer_irq      (timer_irq),
      .o_sw_irq         (sw_irq),
      .o_nmi_int        (nmi_int),
      .o_nmi_vec        (nmi_vec)
   );

   periph_checker u_chk (
      .clk              (clk),
      .i_arst_n         (arst_n),
      .i_wb_adr         (wb_adr),
      .i_wb_dat         (wb_dat),
      .i_wb_we          (wb_we),
      .i_wb_cyc         (wb_cyc),
      .i_wb_stb         (wb_stb),
      .i_wb_rdt         (wb_rdt),
      .i_wb_ack         (wb_ack),
      .i_ram_init_done  (ram_init_done),
      .i_ram_init_error (ram_init_error),
      .i_gpio_in        (gpio_in),
      .i_gpio_out       (gpio_out),
      .i_gpio_oe        (gpio_oe),
      .i_gpio_irq       (gpio_irq),
      .i_sw_irq         (sw_irq),
      .i_nmi_vec        (nmi_vec)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val        = {val[30:0], lfsr_state[0]};
      end
      return val;
   endfunction

   function automatic soc_bus_pkg::wb_adr_t make_adr(input soc_bus_pkg::region_t rgn,
                                                     input soc_bus_pkg::reg_idx_t idx);
      return {rgn, 6'd0, idx, 2'd0};
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $finish;
   endtask

   // ********************
   // Bus master
   // ********************

   task automatic bus_access(input soc_bus_pkg::wb_adr_t a, input logic we,
                             input soc_bus_pkg::wb_dat_t dat,
                             output soc_bus_pkg::wb_dat_t data_out);
      int cnt;
      wb_adr = a;
      wb_dat = dat;
      wb_we  = we;
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      cnt    = 0;
      @(negedge clk);
      while (!wb_ack && cnt < ACK_LIMIT) begin
         @(negedge clk);
         cnt++;
      end
      if (!wb_ack) abort_run("Bus access got no acknowledge within the timeout");
      data_out = wb_rdt;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      @(negedge clk);
   endtask

   task automatic bus_write(input soc_bus_pkg::wb_adr_t a, input soc_bus_pkg::wb_dat_t dat);
      soc_bus_pkg::wb_dat_t unused;
      bus_access(a, 1'b1, dat, unused);
   endtask

   task automatic bus_read(input soc_bus_pkg::wb_adr_t a, output soc_bus_pkg::wb_dat_t dat);
      bus_access(a, 1'b0, '0, dat);
   endtask

   task automatic finish_test(input string name);
      $display("Test %s: finished with %0d errors", name, u_chk.errors - err_mark);
      err_mark = u_chk.errors;
   endtask

   // ********************
   // Test sequence
   // ********************

   initial begin
      arst_n         = 1'b0;
      wb_adr         = '0;
      wb_dat         = '0;
      wb_we          = 1'b0;
      wb_cyc         = 1'b0;
      wb_stb         = 1'b0;
      ram_init_done  = 1'b0;
      ram_init_error = 1'b0;
      gpio_in        = '0;
      lfsr_state     = 32'h963467d2;
      err_mark       = 0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      for (int i = 0; i < 8; i++) begin
         bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_bus_pkg::reg_idx_t'(i)), rdt);
      end
      for (int i = 0; i < 5; i++) begin
         bus_read(make_adr(soc_bus_pkg::REGION_GPIO, soc_bus_pkg::reg_idx_t'(i)), rdt);
      end
      u_chk.check_value("o_timer_irq", 32'(timer_irq), 32'd0);
      u_chk.check_value("o_sw_irq", 32'(sw_irq), 32'd0);
      u_chk.check_value("o_nmi_int", 32'(nmi_int), 32'd0);
      u_chk.check_value("o_gpio_irq", 32'(gpio_irq), 32'd0);
      u_chk.check_value("o_gpio_out", gpio_out, 32'd0);
      u_chk.check_value("o_gpio_oe", gpio_oe, 32'd0);
      finish_test("reset values");

      repeat (24) begin
         sel = int'(rand_bits(3) % 5);
         case (sel)
            0: adr = make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_SW_IRQ);
            1: adr = make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_NMI_VEC);
            2: adr = make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_OUT);
            3: adr = make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_OE);
            default: adr = make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_IRQ_MASK);
         endcase
         bus_write(adr, rand_bits(32));
         bus_read(adr, rdt);
      end
      finish_test("register write and readback");

      // Regions 2 to 15 have nothing behind them
      repeat (8) begin
         region = soc_bus_pkg::region_t'(rand_bits(4));
         if (region < 4'd2) region = region + 4'd2;
         adr = make_adr(region, soc_bus_pkg::reg_idx_t'(rand_bits(4)));
         bus_write(adr, rand_bits(32));
         bus_read(adr, rdt);
      end
      bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_SW_IRQ), rdt);
      bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_NMI_VEC), rdt);
      bus_read(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_OUT), rdt);
      bus_read(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_OE), rdt);
      bus_read(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_IRQ_MASK), rdt);
      finish_test("unmapped regions");

      bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_MTIME_LO), t0);
      bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_MTIME_LO), t1);
      u_chk.check_true(t1 > t0, "timer low word did not increase between two reads");
      bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_MTIME_HI), hi);
      bus_write(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_MTIMECMP_HI), hi);
      bus_write(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_MTIMECMP_LO),
                t1 + 32'd20);
      u_chk.check_value("o_timer_irq", 32'(timer_irq), 32'd0);
      n = 0;
      while (!timer_irq && n < IRQ_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!timer_irq) abort_run("Timer interrupt did not rise after the compare was reached");
      bus_write(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_MTIMECMP_LO), '1);
      bus_write(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_MTIMECMP_HI), '1);
      u_chk.check_value("o_timer_irq", 32'(timer_irq), 32'd0);
      finish_test("machine timer");

      bus_write(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_IRQ_MASK),
                rand_bits(32));
      repeat (12) begin
         gpio_in = rand_bits(32);
         repeat (4) @(negedge clk);
         bus_read(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_IN), rdt);
         bus_read(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_IRQ_STAT), rdt);
      end
      bus_write(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_IRQ_STAT), '1);
      bus_read(make_adr(soc_bus_pkg::REGION_GPIO, soc_periph_pkg::GPIO_IRQ_STAT), rdt);
      u_chk.check_value("GPIO_IRQ_STAT", rdt, 32'd0);
      finish_test("GPIO inputs and interrupts");

      // Done alone, so the two status bits differ
      ram_init_done = 1'b1;
      bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_RAM_STATUS), rdt);
      u_chk.check_value("o_nmi_int", 32'(nmi_int), 32'd0);
      ram_init_error = 1'b1;
      n = 0;
      while (!nmi_int && n < IRQ_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!nmi_int) abort_run("NMI did not rise after the RAM init error");
      bus_read(make_adr(soc_bus_pkg::REGION_SYS, soc_periph_pkg::SYS_RAM_STATUS), rdt);
      ram_init_error = 1'b0;
      repeat (2) @(negedge clk);
      u_chk.check_value("o_nmi_int", 32'(nmi_int), 32'd1);
      finish_test("RAM init error NMI");

      $display("Checks: %0d, errors: %0d", u_chk.checks, u_chk.errors);
      if (u_chk.errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/periph_checker.sv ====
// Register model, bus and output monitor, comparisons and check counts
`default_nettype none

module periph_checker (
   input wire                          clk,
   input wire                          i_arst_n,
   input wire soc_bus_pkg::wb_adr_t    i_wb_adr,
   input wire soc_bus_pkg::wb_dat_t    i_wb_dat,
   input wire                          i_wb_we,
   input wire                          i_wb_cyc,
   input wire                          i_wb_stb,
   input wire soc_bus_pkg::wb_dat_t    i_wb_rdt,
   input wire                          i_wb_ack,
   input wire                          i_ram_init_done,
   input wire                          i_ram_init_error,
   input wire soc_periph_pkg::gpio_t   i_gpio_in,
   input wire soc_periph_pkg::gpio_t   i_gpio_out,
   input wire soc_periph_pkg::gpio_t   i_gpio_oe,
   input wire                          i_gpio_irq,
   input wire soc_periph_pkg::sw_irq_t i_sw_irq,
   input wire soc_bus_pkg::wb_dat_t    i_nmi_vec
);

   timeunit 1ns;
   timeprecision 1ps;

   int                      checks;
   int                      errors;
   soc_periph_pkg::sw_irq_t m_sw_irq;
   soc_bus_pkg::wb_dat_t    m_nmi_vec;
   soc_periph_pkg::mtime_t  m_cmp;
   soc_periph_pkg::gpio_t   m_out;
   soc_periph_pkg::gpio_t   m_oe;
   soc_periph_pkg::gpio_t   m_mask;
   soc_periph_pkg::gpio_t   m_stat;
   soc_periph_pkg::gpio_t   m_meta;
   soc_periph_pkg::gpio_t   m_sync;
   soc_periph_pkg::gpio_t   m_prev;
   soc_periph_pkg::gpio_t   rise;
   soc_periph_pkg::gpio_t   clr;
   logic                    pend;
   logic                    pend_we;
   logic                    pend_timer;
   logic                    pend_stat_rd;
   soc_bus_pkg::wb_dat_t    pend_exp;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input logic ok, input string what);
      checks++;
      if (ok !== 1'b1) begin
         errors++;
         $display("At %0t ns: %s", $time, what);
      end
   endtask

   // ********************
   // Model access
   // ********************

   // Expected read word uses the model state from before this edge
   task automatic start_access(input soc_bus_pkg::wb_adr_t adr, input logic we,
                               input soc_bus_pkg::wb_dat_t dat);
      soc_bus_pkg::region_t  region;
      soc_bus_pkg::reg_idx_t idx;
      region       = adr[15:12];
      idx          = adr[5:2];
      pend_exp     = '0;
      pend_timer   = 1'b0;
      pend_stat_rd = 1'b0;
      if (region == soc_bus_pkg::REGION_SYS) begin
         case (idx)
            soc_periph_pkg::SYS_VERSION:     pend_exp = soc_periph_pkg::VERSION_WORD;
            soc_periph_pkg::SYS_SW_IRQ:      pend_exp = {30'd0, m_sw_irq};
            soc_periph_pkg::SYS_RAM_STATUS:  pend_exp = {30'd0, i_ram_init_error,
                                                         i_ram_init_done};
            soc_periph_pkg::SYS_NMI_VEC:     pend_exp = m_nmi_vec;
            soc_periph_pkg::SYS_MTIME_LO:    pend_timer = 1'b1;
            soc_periph_pkg::SYS_MTIME_HI:    pend_timer = 1'b1;
            soc_periph_pkg::SYS_MTIMECMP_LO: pend_exp = m_cmp[31:0];
            soc_periph_pkg::SYS_MTIMECMP_HI: pend_exp = m_cmp[63:32];
            default: ;
         endcase
         if (we) begin
            case (idx)
               soc_periph_pkg::SYS_SW_IRQ:      m_sw_irq = dat[1:0];
               soc_periph_pkg::SYS_NMI_VEC:     m_nmi_vec = dat;
               soc_periph_pkg::SYS_MTIMECMP_LO: m_cmp[31:0] = dat;
               soc_periph_pkg::SYS_MTIMECMP_HI: m_cmp[63:32] = dat;
               default: ;
            endcase
         end
      end else if (region == soc_bus_pkg::REGION_GPIO) begin
         case (idx)
            soc_periph_pkg::GPIO_IN:       pend_exp = m_sync;
            soc_periph_pkg::GPIO_OUT:      pend_exp = m_out;
            soc_periph_pkg::GPIO_OE:       pend_exp = m_oe;
            soc_periph_pkg::GPIO_IRQ_MASK: pend_exp = m_mask;
            soc_periph_pkg::GPIO_IRQ_STAT: begin
               pend_exp     = m_stat;
               pend_stat_rd = !we;
            end
            default: ;
         endcase
         if (we) begin
            case (idx)
               soc_periph_pkg::GPIO_OUT:      m_out = dat;
               soc_periph_pkg::GPIO_OE:       m_oe = dat;
               soc_periph_pkg::GPIO_IRQ_MASK: m_mask = dat;
               soc_periph_pkg::GPIO_IRQ_STAT: clr = dat;
               default: ;
            endcase
         end
      end
   endtask

   // ********************
   // Bus monitor
   // ********************

   always @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         m_sw_irq  = '0;
         m_nmi_vec = soc_periph_pkg::NMI_VEC_RST;
         m_cmp     = soc_periph_pkg::MTIMECMP_RST;
         m_out     = '0;
         m_oe      = '0;
         m_mask    = '0;
         m_stat    = '0;
         m_meta    = '0;
         m_sync    = '0;
         m_prev    = '0;
         pend      = 1'b0;
      end else begin
         rise = m_sync & ~m_prev & m_mask;
         clr  = '0;
         if (pend) begin
            check_true(i_wb_ack, "no acknowledge one cycle after the strobe");
            if (!pend_we && !pend_timer) begin
               check_value("o_wb_rdt", i_wb_rdt, pend_exp);
            end
            if (pend_stat_rd) begin
               check_value("o_gpio_irq", 32'(i_gpio_irq), 32'(|m_stat));
            end
            if (pend_we) begin
               check_value("o_gpio_out", i_gpio_out, m_out);
               check_value("o_gpio_oe", i_gpio_oe, m_oe);
               check_value("o_sw_irq", 32'(i_sw_irq), 32'(m_sw_irq));
               check_value("o_nmi_vec", i_nmi_vec, m_nmi_vec);
            end
            pend = 1'b0;
         end else if (i_wb_ack) begin
            check_true(1'b0, "acknowledge seen without a pending access");
         end else if (i_wb_cyc && i_wb_stb) begin
            pend    = 1'b1;
            pend_we = i_wb_we;
            start_access(i_wb_adr, i_wb_we, i_wb_dat);
         end
         // Edges seen before this edge still set status over a clear
         m_stat = (m_stat & ~clr) | rise;
         m_prev = m_sync;
         m_sync = m_meta;
         m_meta = i_gpio_in;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/periph_subsys_top.sv ====
// Peripheral subsystem top with decoder, system controller and GPIO
`default_nettype none

module periph_subsys_top (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire soc_bus_pkg::wb_adr_t    i_wb_adr,
   input  wire soc_bus_pkg::wb_dat_t    i_wb_dat,
   input  wire                          i_wb_we,
   input  wire                          i_wb_cyc,
   input  wire                          i_wb_stb,
   output wire soc_bus_pkg::wb_dat_t    o_wb_rdt,
   output wire                          o_wb_ack,
   input  wire                          i_ram_init_done,
   input  wire                          i_ram_init_error,
   input  wire soc_periph_pkg::gpio_t   i_gpio_in,
   output wire soc_periph_pkg::gpio_t   o_gpio_out,
   output wire soc_periph_pkg::gpio_t   o_gpio_oe,
   output wire                          o_gpio_irq,
   output wire                          o_timer_irq,
   output wire soc_periph_pkg::sw_irq_t o_sw_irq,
   output wire                          o_nmi_int,
   output wire soc_bus_pkg::wb_dat_t    o_nmi_vec
);

   soc_bus_pkg::reg_idx_t reg_idx;
   soc_bus_pkg::wb_dat_t  sys_rdt;
   soc_bus_pkg::wb_dat_t  gpio_rdt;
   wire                   sys_stb;
   wire                   sys_ack;
   wire                   gpio_stb;
   wire                   gpio_ack;

   wb_periph_decode u_decode (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_wb_adr   (i_wb_adr),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .i_sys_rdt  (sys_rdt),
      .i_sys_ack  (sys_ack),
      .i_gpio_rdt (gpio_rdt),
      .i_gpio_ack (gpio_ack),
      .o_reg_idx  (reg_idx),
      .o_sys_stb  (sys_stb),
      .o_gpio_stb (gpio_stb),
      .o_wb_rdt   (o_wb_rdt),
      .o_wb_ack   (o_wb_ack)
   );

   sys_ctrl u_sys_ctrl (
      .clk              (clk),
      .i_arst_n         (i_arst_n),
      .i_stb            (sys_stb),
      .i_we             (i_wb_we),
      .i_reg_idx        (reg_idx),
      .i_dat            (i_wb_dat),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_rdt            (sys_rdt),
      .o_ack            (sys_ack),
      .o_timer_irq      (o_timer_irq),
      .o_sw_irq         (o_sw_irq),
      .o_nmi_int        (o_nmi_int),
      .o_nmi_vec        (o_nmi_vec)
   );

   gpio_regs u_gpio (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_stb      (gpio_stb),
      .i_we       (i_wb_we),
      .i_reg_idx  (reg_idx),
      .i_dat      (i_wb_dat),
      .i_gpio_in  (i_gpio_in),
      .o_rdt      (gpio_rdt),
      .o_ack      (gpio_ack),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (o_gpio_irq)
   );

endmodule

`default_nettype wire

// ==== rtl/gpio_regs.sv ====
// GPIO registers, input synchronizer and edge interrupt logic
`default_nettype none

module gpio_regs (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire                          i_stb,
   input  wire                          i_we,
   input  wire soc_bus_pkg::reg_idx_t   i_reg_idx,
   input  wire soc_bus_pkg::wb_dat_t    i_dat,
   input  wire soc_periph_pkg::gpio_t   i_gpio_in,
   output soc_bus_pkg::wb_dat_t         o_rdt,
   output logic                         o_ack,
   output soc_periph_pkg::gpio_t        o_gpio_out,
   output soc_periph_pkg::gpio_t        o_gpio_oe,
   output logic                         o_gpio_irq
);

   soc_periph_pkg::gpio_t in_meta;
   soc_periph_pkg::gpio_t in_sync;
   soc_periph_pkg::gpio_t in_prev;
   soc_periph_pkg::gpio_t irq_mask;
   soc_periph_pkg::gpio_t irq_stat;
   soc_periph_pkg::gpio_t rise;
   soc_periph_pkg::gpio_t stat_clr;
   logic                  acc;
   logic                  wr;

   assign acc = i_stb & ~o_ack;
   assign wr  = acc & i_we;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ack <= 1'b0;
      end else begin
         o_ack <= acc;
      end
   end

   // ********************
   // Input path
   // ********************

   // Two flop synchronizer, then one more stage for edge detect
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         in_meta <= '0;
         in_sync <= '0;
         in_prev <= '0;
      end else begin
         in_meta <= i_gpio_in;
         in_sync <= in_meta;
         in_prev <= in_sync;
      end
   end

   assign rise     = in_sync & ~in_prev & irq_mask;
   assign stat_clr = (wr && i_reg_idx == soc_periph_pkg::GPIO_IRQ_STAT) ? i_dat : '0;

   // New edges win over a clear in the same cycle
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         irq_stat <= '0;
      end else begin
         irq_stat <= (irq_stat & ~stat_clr) | rise;
      end
   end

   assign o_gpio_irq = |irq_stat;

   // ********************
   // Bus registers
   // ********************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         irq_mask   <= '0;
      end else if (wr) begin
         case (i_reg_idx)
            soc_periph_pkg::GPIO_OUT:      o_gpio_out <= i_dat;
            soc_periph_pkg::GPIO_OE:       o_gpio_oe <= i_dat;
            soc_periph_pkg::GPIO_IRQ_MASK: irq_mask <= i_dat;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         case (i_reg_idx)
            soc_periph_pkg::GPIO_IN:       o_rdt <= in_sync;
            soc_periph_pkg::GPIO_OUT:      o_rdt <= o_gpio_out;
            soc_periph_pkg::GPIO_OE:       o_rdt <= o_gpio_oe;
            soc_periph_pkg::GPIO_IRQ_MASK: o_rdt <= irq_mask;
            soc_periph_pkg::GPIO_IRQ_STAT: o_rdt <= irq_stat;
            default:                       o_rdt <= '0;
         endcase
      end
   end

   // Held strobe must not produce a second ack
   assert property (@(posedge clk) disable iff (!i_arst_n)
      o_ack |=> !o_ack);

endmodule

`default_nettype wire

// ==== rtl/sys_ctrl.sv ====
// System controller registers, machine timer and interrupt outputs
`default_nettype none

module sys_ctrl (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire                          i_stb,
   input  wire                          i_we,
   input  wire soc_bus_pkg::reg_idx_t   i_reg_idx,
   input  wire soc_bus_pkg::wb_dat_t    i_dat,
   input  wire                          i_ram_init_done,
   input  wire                          i_ram_init_error,
   output soc_bus_pkg::wb_dat_t         o_rdt,
   output logic                         o_ack,
   output logic                         o_timer_irq,
   output soc_periph_pkg::sw_irq_t      o_sw_irq,
   output logic                         o_nmi_int,
   output soc_bus_pkg::wb_dat_t         o_nmi_vec
);

   soc_periph_pkg::mtime_t mtime;
   soc_periph_pkg::mtime_t mtimecmp;
   logic                   acc;
   logic                   wr;

   // First cycle of a strobe only
   assign acc = i_stb & ~o_ack;
   assign wr  = acc & i_we;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ack <= 1'b0;
      end else begin
         o_ack <= acc;
      end
   end

   // ********************
   // Machine timer
   // ********************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtime <= '0;
      end else if (wr && i_reg_idx == soc_periph_pkg::SYS_MTIME_LO) begin
         mtime[31:0] <= i_dat;
      end else if (wr && i_reg_idx == soc_periph_pkg::SYS_MTIME_HI) begin
         mtime[63:32] <= i_dat;
      end else begin
         mtime <= mtime + 64'd1;
      end
   end

   assign o_timer_irq = (mtime >= mtimecmp);

   // ********************
   // Control registers
   // ********************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         mtimecmp  <= soc_periph_pkg::MTIMECMP_RST;
         o_sw_irq  <= '0;
         o_nmi_vec <= soc_periph_pkg::NMI_VEC_RST;
      end else if (wr) begin
         case (i_reg_idx)
            soc_periph_pkg::SYS_SW_IRQ:      o_sw_irq <= i_dat[1:0];
            soc_periph_pkg::SYS_NMI_VEC:     o_nmi_vec <= i_dat;
            soc_periph_pkg::SYS_MTIMECMP_LO: mtimecmp[31:0] <= i_dat;
            soc_periph_pkg::SYS_MTIMECMP_HI: mtimecmp[63:32] <= i_dat;
            default: ;
         endcase
      end
   end

   // Sticky until reset
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_nmi_int <= 1'b0;
      end else begin
         o_nmi_int <= o_nmi_int | i_ram_init_error;
      end
   end

   // Read word captured on the same edge that raises ack
   always_ff @(posedge clk) begin
      if (acc) begin
         case (i_reg_idx)
            soc_periph_pkg::SYS_VERSION:     o_rdt <= soc_periph_pkg::VERSION_WORD;
            soc_periph_pkg::SYS_SW_IRQ:      o_rdt <= {30'd0, o_sw_irq};
            soc_periph_pkg::SYS_RAM_STATUS:  o_rdt <= {30'd0, i_ram_init_error,
                                                       i_ram_init_done};
            soc_periph_pkg::SYS_NMI_VEC:     o_rdt <= o_nmi_vec;
            soc_periph_pkg::SYS_MTIME_LO:    o_rdt <= mtime[31:0];
            soc_periph_pkg::SYS_MTIME_HI:    o_rdt <= mtime[63:32];
            soc_periph_pkg::SYS_MTIMECMP_LO: o_rdt <= mtimecmp[31:0];
            soc_periph_pkg::SYS_MTIMECMP_HI: o_rdt <= mtimecmp[63:32];
            default:                         o_rdt <= '0;
         endcase
      end
   end

   // No ack without a strobe on the edge before
   assert property (@(posedge clk) disable iff (!i_arst_n)
      o_ack |-> $past(i_stb));

endmodule

`default_nettype wire

// ==== rtl/wb_periph_decode.sv ====
// Region decoder, strobe routing, read data mux and unmapped access ack
`default_nettype none

module wb_periph_decode (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire soc_bus_pkg::wb_adr_t    i_wb_adr,
   input  wire                          i_wb_cyc,
   input  wire                          i_wb_stb,
   input  wire soc_bus_pkg::wb_dat_t    i_sys_rdt,
   input  wire                          i_sys_ack,
   input  wire soc_bus_pkg::wb_dat_t    i_gpio_rdt,
   input  wire                          i_gpio_ack,
   output soc_bus_pkg::reg_idx_t        o_reg_idx,
   output logic                         o_sys_stb,
   output logic                         o_gpio_stb,
   output soc_bus_pkg::wb_dat_t         o_wb_rdt,
   output logic                         o_wb_ack
);

   soc_bus_pkg::region_t region;
   logic                 req;
   logic                 hit_sys;
   logic                 hit_gpio;
   logic                 unmapped_ack;

   // ********************
   // Address decode
   // ********************

   assign region   = i_wb_adr[soc_bus_pkg::WB_ADR_W-1 -: soc_bus_pkg::REGION_W];
   assign req      = i_wb_cyc & i_wb_stb;
   assign hit_sys  = (region == soc_bus_pkg::REGION_SYS);
   assign hit_gpio = (region == soc_bus_pkg::REGION_GPIO);

   assign o_reg_idx  = i_wb_adr[soc_bus_pkg::REG_IDX_W+1:2];
   assign o_sys_stb  = req & hit_sys;
   assign o_gpio_stb = req & hit_gpio;

   // Nobody home, answer anyway so the master never hangs
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         unmapped_ack <= 1'b0;
      end else begin
         unmapped_ack <= req & ~hit_sys & ~hit_gpio & ~unmapped_ack;
      end
   end

   // ********************
   // Response return
   // ********************

   // Steer by whichever ack is up, zero otherwise
   always_comb begin
      if (i_sys_ack) begin
         o_wb_rdt = i_sys_rdt;
      end else if (i_gpio_ack) begin
         o_wb_rdt = i_gpio_rdt;
      end else begin
         o_wb_rdt = '0;
      end
   end

   assign o_wb_ack = i_sys_ack | i_gpio_ack | unmapped_ack;

   // At most one responder per cycle across both peripherals
   assert property (@(posedge clk) disable iff (!i_arst_n)
      $onehot0({i_sys_ack, i_gpio_ack, unmapped_ack}));

endmodule

`default_nettype wire

// ==== rtl/soc_periph_pkg.sv ====
// Peripheral register indices, reset values and data types
`default_nettype none

package soc_periph_pkg;

   typedef logic [63:0] mtime_t;
   typedef logic [31:0] gpio_t;

   localparam int SW_IRQ_W = 2;

   typedef logic [SW_IRQ_W-1:0] sw_irq_t;

   // System controller map
   localparam soc_bus_pkg::reg_idx_t SYS_VERSION     = 4'd0;
   localparam soc_bus_pkg::reg_idx_t SYS_SW_IRQ      = 4'd1;
   localparam soc_bus_pkg::reg_idx_t SYS_RAM_STATUS  = 4'd2;
   localparam soc_bus_pkg::reg_idx_t SYS_NMI_VEC     = 4'd3;
   localparam soc_bus_pkg::reg_idx_t SYS_MTIME_LO    = 4'd4;
   localparam soc_bus_pkg::reg_idx_t SYS_MTIME_HI    = 4'd5;
   localparam soc_bus_pkg::reg_idx_t SYS_MTIMECMP_LO = 4'd6;
   localparam soc_bus_pkg::reg_idx_t SYS_MTIMECMP_HI = 4'd7;

   // GPIO map
   localparam soc_bus_pkg::reg_idx_t GPIO_IN       = 4'd0;
   localparam soc_bus_pkg::reg_idx_t GPIO_OUT      = 4'd1;
   localparam soc_bus_pkg::reg_idx_t GPIO_OE       = 4'd2;
   localparam soc_bus_pkg::reg_idx_t GPIO_IRQ_MASK = 4'd3;
   localparam soc_bus_pkg::reg_idx_t GPIO_IRQ_STAT = 4'd4;

   // Reset and constant values
   localparam soc_bus_pkg::wb_dat_t VERSION_WORD = 32'h0002_0100;
   localparam soc_bus_pkg::wb_dat_t NMI_VEC_RST  = 32'h4000_0000;
   localparam mtime_t               MTIMECMP_RST = '1;

endpackage

`default_nettype wire

// ==== rtl/soc_bus_pkg.sv ====
// Wishbone widths, address region map and bus vector types
`default_nettype none

package soc_bus_pkg;

   // ********************
   // Bus widths
   // ********************

   localparam int WB_ADR_W = 16;
   localparam int WB_DAT_W = 32;

   typedef logic [WB_ADR_W-1:0] wb_adr_t;
   typedef logic [WB_DAT_W-1:0] wb_dat_t;

   // ********************
   // Region map
   // ********************

   // Region select sits in the top address nibble
   localparam int REGION_W = 4;

   typedef logic [REGION_W-1:0] region_t;

   localparam region_t REGION_SYS  = 4'd0;
   localparam region_t REGION_GPIO = 4'd1;

   // Word index within a region, address bits 5 to 2
   localparam int REG_IDX_W = 4;

   typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

`default_nettype wire
